//--- source/videoPipePkg.sv
// shared pixel types and constants; all layout values assume the 160x144 console screen on hClk
package videoPipePkg;

    typedef logic [14:0] gbPixelT;   // {b5, g5, r5} with red lowest
    typedef logic [17:0] pixelT;     // {b6, g6, r6}
    typedef logic [15:0] osdPixelT;  // RGB565 with blue in [4:0]
    typedef logic [7:0]  coordT;
    typedef logic [22:0] fbAddrT;

    typedef enum logic [1:0] {
        show     = 2'b00,
        blink    = 2'b01,
        hide     = 2'b10,
        reserved = 2'b11
    } lowBattModeT;

    // frame-buffer layout
    localparam fbAddrT fbBaseAddr   = 23'h10000;
    localparam fbAddrT fbLineStride = 23'd320;

    localparam osdPixelT osdKeyColor = 16'hF81F;  // magenta means transparent

    // inclusive battery icon bounds
    localparam coordT battBackX0  = 8'd140;
    localparam coordT battBackX1  = 8'd155;
    localparam coordT battBackY0  = 8'd4;
    localparam coordT battBackY1  = 8'd11;
    localparam coordT battFrontX0 = 8'd142;
    localparam coordT battFrontX1 = 8'd153;
    localparam coordT battFrontY0 = 8'd6;
    localparam coordT battFrontY1 = 8'd9;

    localparam pixelT colorRed = {6'h00, 6'h00, 6'h3F};

    // LCD correction matrix by output channel
    localparam logic [7:0] corrRedR   = 8'd216;
    localparam logic [7:0] corrRedG   = 8'd30;
    localparam logic [7:0] corrRedB   = 8'd25;  // subtracted
    localparam logic [7:0] corrGreenR = 8'd39;
    localparam logic [7:0] corrGreenG = 8'd137;
    localparam logic [7:0] corrGreenB = 8'd24;
    localparam logic [7:0] corrBlueR  = 8'd21;
    localparam logic [7:0] corrBlueG  = 8'd24;
    localparam logic [7:0] corrBlueB  = 8'd125;

endpackage

//--- source/rasterTracker.sv
// raster position and frame-buffer line address from sync edges; fbNewLine is high while hsync is low after a high cycle
module rasterTracker
    import videoPipePkg::*;
(
    input  logic   hClk,
    input  logic   rstN,
    input  logic   gbValid,
    input  logic   gbHsync,
    input  logic   gbVsync,
    input  logic   menuBtn,
    output coordT  screenX,
    output coordT  screenY,
    output logic   fbNewLine,
    output fbAddrT fbAddress,
    output logic   drawOsd
);

    logic hsyncPrev;
    logic vsyncPrev;
    logic hsyncRise;
    logic vsyncRise;

    assign hsyncRise = gbHsync & ~hsyncPrev;
    assign vsyncRise = gbVsync & ~vsyncPrev;
    assign fbNewLine = ~gbHsync & hsyncPrev;  // end of line

    always_ff @(posedge hClk or negedge rstN) begin
        if (!rstN) begin
            hsyncPrev <= 1'b0;
            vsyncPrev <= 1'b0;
        end else begin
            hsyncPrev <= gbHsync;
            vsyncPrev <= gbVsync;
        end
    end

    always_ff @(posedge hClk or negedge rstN) begin
        if (!rstN) begin
            fbAddress <= fbBaseAddr;
        end else if (vsyncRise) begin
            fbAddress <= fbBaseAddr;
        end else if (fbNewLine && !gbVsync) begin
            fbAddress <= fbAddress + fbLineStride;  // no stepping during vblank
        end
    end

    always_ff @(posedge hClk or negedge rstN) begin
        if (!rstN) begin
            screenX <= '0;
            screenY <= '0;
        end else begin
            if (hsyncRise) begin
                screenX <= '0;
                screenY <= screenY + 1'b1;
            end else if (gbValid) begin
                screenX <= screenX + 1'b1;
            end
            if (vsyncRise)
                screenY <= '0;  // frame start wins over row step
        end
    end

    // menu sampled once per frame from the active-low button
    always_ff @(posedge hClk or negedge rstN) begin
        if (!rstN)
            drawOsd <= 1'b0;
        else if (vsyncRise)
            drawOsd <= ~menuBtn;
    end

endmodule

//--- source/pixelCorrector.sv
// frame blend and LCD colour matrix with one register stage; sync and valid share that stage
module pixelCorrector
    import videoPipePkg::*;
(
    input  logic    hClk,
    input  logic    rstN,
    input  logic    gbValid,
    input  logic    gbHsync,
    input  logic    gbVsync,
    input  gbPixelT gbPixel,
    input  gbPixelT prevPixel,
    input  logic    blendEnable,
    input  logic    correctEnable,
    output logic    lcdValid,
    output logic    lcdHsync,
    output logic    lcdVsync,
    output pixelT   correctedPixel
);

    logic [5:0]  blendR;
    logic [5:0]  blendG;
    logic [5:0]  blendB;
    pixelT       blendPixel;
    logic [15:0] redPos;
    logic [15:0] redNeg;
    logic [15:0] redSum;
    logic [15:0] greenSum;
    logic [15:0] blueSum;
    pixelT       matrixPixel;

    function automatic logic [5:0] blendChannel(input logic [4:0] cur, input logic [4:0] prev,
                                                input logic enable);
        if (enable)
            return {1'b0, cur} + {1'b0, prev};
        return {cur, 1'b0};
    endfunction

    // saturate on overflow past bit 12
    function automatic logic [5:0] satChannel(input logic [15:0] value);
        return value[13] ? 6'h3F : value[12:7];
    endfunction

    assign blendR     = blendChannel(gbPixel[4:0], prevPixel[4:0], blendEnable);
    assign blendG     = blendChannel(gbPixel[9:5], prevPixel[9:5], blendEnable);
    assign blendB     = blendChannel(gbPixel[14:10], prevPixel[14:10], blendEnable);
    assign blendPixel = {blendB, blendG, blendR};

    // matrix runs on the top 5 bits of each channel
    assign redPos   = blendR[5:1] * corrRedR + blendG[5:1] * corrRedG;
    assign redNeg   = blendB[5:1] * corrRedB;
    assign redSum   = (redPos < redNeg) ? '0 : redPos - redNeg;  // clamp at zero
    assign greenSum = blendR[5:1] * corrGreenR + blendG[5:1] * corrGreenG
                    + blendB[5:1] * corrGreenB;
    assign blueSum  = blendR[5:1] * corrBlueR + blendG[5:1] * corrBlueG
                    + blendB[5:1] * corrBlueB;

    assign matrixPixel = {satChannel(blueSum), satChannel(greenSum), satChannel(redSum)};

    always_ff @(posedge hClk or negedge rstN) begin
        if (!rstN) begin
            lcdValid       <= 1'b0;
            lcdHsync       <= 1'b0;
            lcdVsync       <= 1'b0;
            correctedPixel <= '0;
        end else begin
            lcdValid       <= gbValid;
            lcdHsync       <= gbHsync;
            lcdVsync       <= gbVsync;
            correctedPixel <= correctEnable ? matrixPixel : blendPixel;
        end
    end

endmodule

//--- source/lowBattBlinker.sv
// low-battery icon visibility; secondTick must be a single-cycle enable
module lowBattBlinker
    import videoPipePkg::*;
(
    input  logic        hClk,
    input  logic        rstN,
    input  lowBattModeT lowBattMode,
    input  logic        secondTick,
    output logic        showLowBatt
);

    typedef enum logic {
        blinkHidden = 1'b0,
        blinkShown  = 1'b1
    } blinkStateT;

    blinkStateT blinkState;

    always_ff @(posedge hClk or negedge rstN) begin
        if (!rstN) begin
            blinkState  <= blinkHidden;
            showLowBatt <= 1'b0;
        end else begin
            unique case (lowBattMode)
                blink: begin
                    if (secondTick)
                        blinkState <= (blinkState == blinkShown) ? blinkHidden : blinkShown;
                    showLowBatt <= (blinkState == blinkShown);  // lags state by a cycle
                end
                hide: begin
                    blinkState  <= blinkHidden;
                    showLowBatt <= 1'b0;
                end
                default: begin  // show and reserved
                    blinkState  <= blinkHidden;
                    showLowBatt <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- source/osdOverlay.sv
// OSD and battery overlay; decisions register alongside the corrected pixel and the final mix is combinational
module osdOverlay
    import videoPipePkg::*;
(
    input  logic     hClk,
    input  logic     rstN,
    input  coordT    screenX,
    input  coordT    screenY,
    input  logic     drawOsd,
    input  osdPixelT osdPixel,
    input  logic     voltageLow,
    input  logic     showLowBatt,
    input  pixelT    correctedPixel,
    output pixelT    lcdPixel
);

    logic  inBattFront;
    logic  inBattBack;
    logic  battOn;
    logic  osdKey;
    pixelT osdColor;
    logic  overlayActive;
    logic  overlayCrush;
    pixelT overlayColor;

    // keep top 4 bits of each channel
    function automatic pixelT darken(input pixelT pix);
        return {2'b00, pix[17:14], 2'b00, pix[11:8], 2'b00, pix[5:2]};
    endfunction

    assign inBattFront = (screenX >= battFrontX0) && (screenX <= battFrontX1)
                      && (screenY >= battFrontY0) && (screenY <= battFrontY1);
    assign inBattBack  = (screenX >= battBackX0) && (screenX <= battBackX1)
                      && (screenY >= battBackY0) && (screenY <= battBackY1);
    assign battOn      = voltageLow & showLowBatt;
    assign osdKey      = (osdPixel == osdKeyColor);

    // OSD blue lands in panel red with its low bit repeated
    assign osdColor = {osdPixel[15:11], osdPixel[11],
                       osdPixel[10:5],
                       osdPixel[4:0], osdPixel[0]};

    always_ff @(posedge hClk or negedge rstN) begin
        if (!rstN) begin
            overlayActive <= 1'b0;
            overlayCrush  <= 1'b0;
        end else if (drawOsd) begin
            overlayActive <= ~osdKey;
            overlayCrush  <= osdKey;
        end else if (battOn && inBattFront) begin
            overlayActive <= 1'b1;
            overlayCrush  <= 1'b0;
        end else if (battOn && inBattBack) begin
            overlayActive <= 1'b0;
            overlayCrush  <= 1'b1;  // outline darkens the game
        end else begin
            overlayActive <= 1'b0;
            overlayCrush  <= 1'b0;
        end
    end

    always_ff @(posedge hClk or negedge rstN) begin
        if (!rstN)
            overlayColor <= '0;
        else
            overlayColor <= drawOsd ? osdColor : colorRed;
    end

    assign lcdPixel = overlayCrush  ? darken(correctedPixel) :
                      overlayActive ? overlayColor : correctedPixel;

endmodule

//--- source/videoPipeTop.sv
// console-to-panel pixel path on hClk without back-pressure; LCD outputs lag inputs by one cycle
module videoPipeTop
    import videoPipePkg::*;
(
    input  logic        hClk,
    input  logic        rstN,
    input  logic        gbValid,
    input  logic        gbHsync,
    input  logic        gbVsync,
    input  gbPixelT     gbPixel,
    input  gbPixelT     prevPixel,
    input  osdPixelT    osdPixel,
    input  logic        menuBtn,
    input  logic        blendEnable,
    input  logic        correctEnable,
    input  logic        voltageLow,
    input  lowBattModeT lowBattMode,
    input  logic        secondTick,
    output logic        fbNewLine,
    output fbAddrT      fbAddress,
    output logic        fbWrite,
    output logic [15:0] fbData,
    output logic        lcdValid,
    output logic        lcdHsync,
    output logic        lcdVsync,
    output pixelT       lcdPixel
);

    coordT screenX;
    coordT screenY;
    logic  drawOsd;
    logic  showLowBatt;
    pixelT correctedPixel;

    assign fbWrite = gbValid;
    assign fbData  = {1'b0, gbPixel};  // raw pixel to frame buffer

    rasterTracker tracker0 (
        .hClk      (hClk),
        .rstN      (rstN),
        .gbValid   (gbValid),
        .gbHsync   (gbHsync),
        .gbVsync   (gbVsync),
        .menuBtn   (menuBtn),
        .screenX   (screenX),
        .screenY   (screenY),
        .fbNewLine (fbNewLine),
        .fbAddress (fbAddress),
        .drawOsd   (drawOsd)
    );

    pixelCorrector corrector0 (
        .hClk           (hClk),
        .rstN           (rstN),
        .gbValid        (gbValid),
        .gbHsync        (gbHsync),
        .gbVsync        (gbVsync),
        .gbPixel        (gbPixel),
        .prevPixel      (prevPixel),
        .blendEnable    (blendEnable),
        .correctEnable  (correctEnable),
        .lcdValid       (lcdValid),
        .lcdHsync       (lcdHsync),
        .lcdVsync       (lcdVsync),
        .correctedPixel (correctedPixel)
    );

    lowBattBlinker blinker0 (
        .hClk        (hClk),
        .rstN        (rstN),
        .lowBattMode (lowBattMode),
        .secondTick  (secondTick),
        .showLowBatt (showLowBatt)
    );

    osdOverlay overlay0 (
        .hClk           (hClk),
        .rstN           (rstN),
        .screenX        (screenX),
        .screenY        (screenY),
        .drawOsd        (drawOsd),
        .osdPixel       (osdPixel),
        .voltageLow     (voltageLow),
        .showLowBatt    (showLowBatt),
        .correctedPixel (correctedPixel),
        .lcdPixel       (lcdPixel)
    );

endmodule

//--- sim/videoPipe_checker.sv
// port-level checks bound to videoPipeTop; samples on the rising edge of hClk
module videoPipe_checker
    import videoPipePkg::*;
(
    input logic  hClk,
    input logic  rstN,
    input logic  gbValid,
    input logic  fbNewLine,
    input logic  lcdValid,
    input logic  lcdHsync,
    input logic  lcdVsync,
    input pixelT lcdPixel
);
    timeunit 1ns;
    timeprecision 1ps;

    validDelay: assert property (@(posedge hClk) disable iff (!rstN)
        lcdValid == $past(gbValid))
        else $error("lcdValid is not gbValid delayed by one cycle");

    // end of line is a single-cycle pulse
    newLinePulse: assert property (@(posedge hClk) disable iff (!rstN)
        fbNewLine |=> !fbNewLine)
        else $error("fbNewLine high in two consecutive cycles");

    resetQuiet: assert property (@(posedge hClk)
        !rstN |-> (!lcdValid && !lcdHsync && !lcdVsync && !fbNewLine && lcdPixel == '0))
        else $error("outputs active while rstN is low");

endmodule

//--- sim/videoPipeModel.svh
// reference pixel functions; include inside a scope that already imports videoPipePkg
`ifndef VIDEO_PIPE_MODEL_SVH
`define VIDEO_PIPE_MODEL_SVH

function automatic pixelT modelBlend(input gbPixelT cur, input gbPixelT prev, input bit enable);
    pixelT result;
    for (int i = 0; i < 3; i++) begin
        if (enable)
            result[6*i +: 6] = {1'b0, cur[5*i +: 5]} + {1'b0, prev[5*i +: 5]};
        else
            result[6*i +: 6] = {cur[5*i +: 5], 1'b0};
    end
    return result;
endfunction

function automatic logic [5:0] modelSat(input int value);
    if (((value >> 13) & 1) != 0)
        return 6'h3F;
    return 6'((value >> 7) & 63);
endfunction

function automatic pixelT modelCorrect(input pixelT pix, input bit enable);
    int r;
    int g;
    int b;
    int red;
    int green;
    int blue;
    if (!enable)
        return pix;
    r = pix[5:1];
    g = pix[11:7];
    b = pix[17:13];
    red = int'(corrRedR) * r + int'(corrRedG) * g - int'(corrRedB) * b;
    if (red < 0)
        red = 0;
    green = int'(corrGreenR) * r + int'(corrGreenG) * g + int'(corrGreenB) * b;
    blue  = int'(corrBlueR) * r + int'(corrBlueG) * g + int'(corrBlueB) * b;
    return {modelSat(blue), modelSat(green), modelSat(red)};
endfunction

function automatic pixelT modelDarken(input pixelT pix);
    pixelT result;
    for (int i = 0; i < 3; i++)
        result[6*i +: 6] = pix[6*i +: 6] >> 2;
    return result;
endfunction

// OSD blue goes to panel red
function automatic pixelT modelOsdExpand(input osdPixelT osd);
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    red   = osd[15:11];
    green = osd[10:5];  // already six bits
    blue  = osd[4:0];
    return {red, red[0], green, blue, blue[0]};
endfunction

`endif

//--- sim/videoPipeTb.sv
// testbench for videoPipeTop; every table row is one frame whose last valid pixel lands at (x, y)
module videoPipeTb
    import videoPipePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "videoPipeModel.svh"

    localparam int edgeLimit = 200;  // 1 ns polls per edge

    typedef struct {
        string       name;
        bit          blend;
        bit          correct;
        bit          menuBtn;
        bit          voltLow;
        lowBattModeT mode;
        int          tickLead;  // cycles from secondTick to the pixel or 0 for none
        int          x;
        int          y;
        gbPixelT     pix;
        gbPixelT     prev;
        osdPixelT    osd;
        pixelT       expected;
    } testRowT;

    logic        hClk;
    logic        rstN;
    logic        gbValid;
    logic        gbHsync;
    logic        gbVsync;
    gbPixelT     gbPixel;
    gbPixelT     prevPixel;
    osdPixelT    osdPixel;
    logic        menuBtn;
    logic        blendEnable;
    logic        correctEnable;
    logic        voltageLow;
    lowBattModeT lowBattMode;
    logic        secondTick;
    logic        fbNewLine;
    fbAddrT      fbAddress;
    logic        fbWrite;
    logic [15:0] fbData;
    logic        lcdValid;
    logic        lcdHsync;
    logic        lcdVsync;
    pixelT       lcdPixel;

    testRowT rows[$];
    int      seed = 28;
    logic    lastValid;
    logic    lastHsync;
    logic    lastVsync;
    fbAddrT  expAddr;

    videoPipeTop dut0 (.*);

    bind videoPipeTop videoPipe_checker checker0 (
        .hClk      (hClk),
        .rstN      (rstN),
        .gbValid   (gbValid),
        .fbNewLine (fbNewLine),
        .lcdValid  (lcdValid),
        .lcdHsync  (lcdHsync),
        .lcdVsync  (lcdVsync),
        .lcdPixel  (lcdPixel)
    );

    initial begin
        hClk = 1'b0;
        forever #50 hClk = ~hClk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic failValue(input string test, input string what,
                             input logic [31:0] expVal, input logic [31:0] actVal);
        abortRun($sformatf("ERR %s %s: expected %h, actual %h", test, what, expVal, actVal));
    endtask

    task automatic nextEdge;
        int guard;
        guard = 0;
        while (hClk !== 1'b0 && guard < edgeLimit) begin
            #1;
            guard++;
        end
        while (hClk !== 1'b1 && guard < edgeLimit) begin
            #1;
            guard++;
        end
        if (guard >= edgeLimit)
            abortRun("clock did not reach a rising edge in time");
    endtask

    function automatic pixelT corrected(input gbPixelT pix, input gbPixelT prev,
                                        input bit blend, input bit correct);
        return modelCorrect(modelBlend(pix, prev, blend), correct);
    endfunction

    task automatic addRow(input string name, input bit blend, input bit correct,
                          input bit menu, input bit volt, input lowBattModeT mode,
                          input int tickLead, input int x, input int y, input gbPixelT pix,
                          input gbPixelT prev, input osdPixelT osd, input pixelT expected);
        testRowT row;
        row = '{name, blend, correct, menu, volt, mode, tickLead, x, y, pix, prev, osd,
                expected};
        rows.push_back(row);
    endtask

    // one clock that checks last cycle's results and then drives the next inputs
    task automatic step(input testRowT row, input logic valid, input logic hsync,
                        input logic vsync, input gbPixelT pix, input logic tick,
                        input bit checkPix);
        nextEdge();
        #10;
        assert ({lcdValid, lcdHsync, lcdVsync} == {lastValid, lastHsync, lastVsync})
            else failValue(row.name, "lcd flags", {lastValid, lastHsync, lastVsync},
                           {lcdValid, lcdHsync, lcdVsync});
        assert (fbAddress == expAddr)
            else failValue(row.name, "fbAddress", expAddr, fbAddress);
        if (checkPix) begin
            assert (lcdPixel == row.expected)
                else failValue(row.name, "lcdPixel", row.expected, lcdPixel);
        end
        gbValid       = valid;
        gbHsync       = hsync;
        gbVsync       = vsync;
        gbPixel       = pix;
        prevPixel     = row.prev;
        osdPixel      = row.osd;
        menuBtn       = row.menuBtn;
        blendEnable   = row.blend;
        correctEnable = row.correct;
        voltageLow    = row.voltLow;
        lowBattMode   = row.mode;
        secondTick    = tick;
        #1;
        assert (fbWrite == valid) else failValue(row.name, "fbWrite", valid, fbWrite);
        assert (fbData == {1'b0, pix}) else failValue(row.name, "fbData", {1'b0, pix}, fbData);
        assert (fbNewLine == (lastHsync && !hsync))
            else failValue(row.name, "fbNewLine", lastHsync && !hsync, fbNewLine);
        if (vsync && !lastVsync)
            expAddr = fbBaseAddr;  // frame start
        else if (lastHsync && !hsync && !vsync)
            expAddr = expAddr + fbLineStride;
        lastValid = valid;
        lastHsync = hsync;
        lastVsync = vsync;
    endtask

    task automatic runRow(input testRowT row);
        int target;
        int tickCycle;
        int k;
        target    = 2 + 2 * row.y + row.x;
        tickCycle = (row.tickLead == 0) ? -1 : target - row.tickLead;
        k = 0;
        step(row, 1'b0, 1'b1, 1'b1, 15'(k * 113 + 7), k == tickCycle, 1'b0);
        k++;
        step(row, 1'b0, 1'b0, 1'b1, 15'(k * 113 + 7), k == tickCycle, 1'b0);  // line end in vblank
        k++;
        repeat (row.y) begin
            step(row, 1'b0, 1'b1, 1'b0, 15'(k * 113 + 7), k == tickCycle, 1'b0);
            k++;
            step(row, 1'b0, 1'b0, 1'b0, 15'(k * 113 + 7), k == tickCycle, 1'b0);
            k++;
        end
        repeat (row.x) begin
            step(row, 1'b1, 1'b0, 1'b0, 15'(k * 113 + 7), k == tickCycle, 1'b0);
            k++;
        end
        step(row, 1'b1, 1'b0, 1'b0, row.pix, k == tickCycle, 1'b0);  // pixel under test
        step(row, 1'b0, 1'b0, 1'b0, 15'h0, 1'b0, 1'b1);
    endtask

    task automatic buildTable;
        gbPixelT p;
        gbPixelT q;
        pixelT   game;
        game = corrected(15'h5A5A, 15'h0, 1'b0, 1'b0);  // game pixel under the battery icon
        addRow("plainWhite", 0, 0, 1, 0, hide, 0, 2, 1, 15'h7FFF, 15'h0, osdKeyColor,
               corrected(15'h7FFF, 15'h0, 0, 0));
        addRow("plainMixed", 0, 0, 1, 0, hide, 0, 9, 2, 15'h2A5C, 15'h0421, osdKeyColor,
               corrected(15'h2A5C, 15'h0421, 0, 0));
        addRow("redClamp", 0, 1, 1, 0, hide, 0, 4, 1, 15'h7C00, 15'h0, osdKeyColor,
               corrected(15'h7C00, 15'h0, 0, 1));
        addRow("fullScale", 1, 1, 1, 0, hide, 0, 4, 1, 15'h7FFF, 15'h7FFF, osdKeyColor,
               corrected(15'h7FFF, 15'h7FFF, 1, 1));
        for (int c = 0; c < 4; c++) begin
            repeat (2) begin
                p = 15'($random(seed));
                q = 15'($random(seed));
                addRow($sformatf("random%0d", c), c[0], c[1], 1, 0, hide, 0, 3 + c, 1, p, q,
                       osdKeyColor, corrected(p, q, c[0], c[1]));
            end
        end
        addRow("osdKey", 0, 1, 0, 0, hide, 0, 6, 3, 15'h3DEF, 15'h0, osdKeyColor,
               modelDarken(corrected(15'h3DEF, 15'h0, 0, 1)));
        addRow("osdColor", 1, 0, 0, 0, hide, 0, 6, 3, 15'h3DEF, 15'h0, 16'h8A53,
               modelOsdExpand(16'h8A53));
        addRow("osdOff", 1, 0, 1, 0, hide, 0, 6, 3, 15'h3DEF, 15'h0, 16'h8A53,
               corrected(15'h3DEF, 15'h0, 1, 0));
        addRow("battShowFront", 0, 0, 1, 1, show, 0, 145, 7, 15'h5A5A, 15'h0, 16'h0, colorRed);
        addRow("battShowBack", 0, 0, 1, 1, show, 0, 140, 4, 15'h5A5A, 15'h0, 16'h0,
               modelDarken(game));
        addRow("battResFront", 0, 0, 1, 1, reserved, 0, 153, 9, 15'h5A5A, 15'h0, 16'h0,
               colorRed);
        addRow("battResBack", 0, 0, 1, 1, reserved, 0, 155, 11, 15'h5A5A, 15'h0, 16'h0,
               modelDarken(game));
        addRow("battOutside", 0, 0, 1, 1, show, 0, 156, 7, 15'h5A5A, 15'h0, 16'h0, game);
        addRow("battHide", 0, 0, 1, 1, hide, 0, 145, 7, 15'h5A5A, 15'h0, 16'h0, game);
        addRow("battNoVolt", 0, 0, 1, 0, show, 0, 145, 7, 15'h5A5A, 15'h0, 16'h0, game);
        // blink state carries over from row to row
        addRow("blinkIdle", 0, 0, 1, 1, blink, 0, 145, 7, 15'h5A5A, 15'h0, 16'h0, game);
        addRow("blinkLag", 0, 0, 1, 1, blink, 1, 145, 7, 15'h5A5A, 15'h0, 16'h0, game);
        addRow("blinkShown", 0, 0, 1, 1, blink, 0, 145, 7, 15'h5A5A, 15'h0, 16'h0, colorRed);
        addRow("blinkOff", 0, 0, 1, 1, blink, 2, 145, 7, 15'h5A5A, 15'h0, 16'h0, game);
        addRow("blinkBack", 0, 0, 1, 1, blink, 40, 141, 5, 15'h5A5A, 15'h0, 16'h0,
               modelDarken(game));
    endtask

    initial begin
        rstN          = 1'b0;
        gbValid       = 1'b0;
        gbHsync       = 1'b0;
        gbVsync       = 1'b0;
        gbPixel       = '0;
        prevPixel     = '0;
        osdPixel      = '0;
        menuBtn       = 1'b1;
        blendEnable   = 1'b0;
        correctEnable = 1'b0;
        voltageLow    = 1'b0;
        lowBattMode   = hide;
        secondTick    = 1'b0;
        lastValid     = 1'b0;
        lastHsync     = 1'b0;
        lastVsync     = 1'b0;
        expAddr       = fbBaseAddr;
        buildTable();
        #0.5;  // polls stay off the clock edges
        repeat (5) nextEdge();
        #10;
        rstN = 1'b1;
        foreach (rows[i])
            runRow(rows[i]);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- videoPipeTop.f
+incdir+sim
source/videoPipePkg.sv
source/rasterTracker.sv
source/pixelCorrector.sv
source/lowBattBlinker.sv
source/osdOverlay.sv
source/videoPipeTop.sv
sim/videoPipe_checker.sv
sim/videoPipeTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the videoPipeTop testbench with Verilator, result taken from sim.log
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f videoPipeTop.f \
    --top-module videoPipeTb -o videoPipeSim \
    && ./obj_dir/videoPipeSim 2>&1 | tee sim.log \
    && ! grep -q "SOME TESTS FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
